// File: project.f
hdl/mips_pkg.sv
hdl/mips_control.sv
hdl/mips_alu_control.sv
hdl/mips_alu.sv
hdl/mips_regfile.sv
hdl/mips_muldiv.sv
hdl/mips_pc.sv
hdl/mips_cpu_harvard.sv
testbench/mips_tb_memory.sv
testbench/mips_cpu_tb.sv

// File: Bender.yml
package:
  name: mips_cpu_harvard

sources:
  - hdl/mips_pkg.sv
  - hdl/mips_control.sv
  - hdl/mips_alu_control.sv
  - hdl/mips_alu.sv
  - hdl/mips_regfile.sv
  - hdl/mips_muldiv.sv
  - hdl/mips_pc.sv
  - hdl/mips_cpu_harvard.sv
  - target: test
    files:
      - testbench/mips_tb_memory.sv
      - testbench/mips_cpu_tb.sv

// File: testbench/mips_cpu_tb.sv
`timescale 1ns/1ps

module mips_cpu_tb;
    import mips_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int CYCLES_PER_TEST = 2000;
    localparam int TEST_COUNT      = 5;

    logic        clk;
    logic        arst_n;
    logic        clk_enable;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    integer      seed;
    int          prog_len;
    // Expected register contents from the instruction definitions
    logic [31:0] gold [32];

    mips_cpu_harvard #(
        .ADDR_WIDTH (32)
    ) DUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .clk_enable     (clk_enable),
        .active         (active),
        .register_v0    (register_v0),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    mips_tb_memory mem (
        .clk            (clk),
        .clk_enable     (clk_enable),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped after the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h",
                                     name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Instruction word builders for the R, I and J formats
    function automatic logic [31:0] r_format(input funct_e funct, input int rs, input int rt,
                                             input int rd, input int shamt);
        mips_instr_t w;
        w.r.opcode = OP_SPECIAL;
        w.r.rs     = 5'(rs);
        w.r.rt     = 5'(rt);
        w.r.rd     = 5'(rd);
        w.r.shamt  = 5'(shamt);
        w.r.funct  = funct;
        return w;
    endfunction

    function automatic logic [31:0] i_format(input opcode_e op, input int rs, input int rt,
                                             input logic [15:0] imm);
        mips_instr_t w;
        w.i.opcode = op;
        w.i.rs     = 5'(rs);
        w.i.rt     = 5'(rt);
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic logic [31:0] j_format(input opcode_e op, input logic [25:0] target);
        mips_instr_t w;
        w.j.opcode = op;
        w.j.target = target;
        return w;
    endfunction

    // J-format target field for an instruction slot in the ROM
    function automatic logic [25:0] jump_field(input int index);
        logic [31:0] target;
        target = reset_vector + 32'(index * 4);
        return target[27:2];
    endfunction

    task automatic add_instr(input logic [31:0] word);
        mem.rom[prog_len] = word;
        prog_len++;
    endtask

    task automatic begin_program();
        @(negedge clk);
        arst_n     = 1'b0;
        clk_enable = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem.rom[i] = 32'b0;
            mem.ram[i] = 32'b0;
        end
        for (int i = 0; i < 32; i++) begin
            gold[i] = 32'b0;
        end
        mem.write_count = 0;
        prog_len        = 0;
    endtask

    // Release reset and wait for the halt with optional random stalls
    task automatic run_program(input logic stall);
        repeat (10) @(negedge clk);
        arst_n     = 1'b1;
        clk_enable = 1'b1;
        while (active !== 1'b0) begin
            @(negedge clk);
            if (stall) begin
                clk_enable = 1'($random(seed));
            end
        end
        clk_enable = 1'b1;
    endtask

    // Checksum of a register range into v0 by alternating xor and addu
    task automatic fold_into_v0(input int first, input int last);
        for (int r = first; r <= last; r++) begin
            if ((r - first) % 2 == 0) begin
                add_instr(r_format(FN_XOR, 2, r, 2, 0));
                gold[2] = gold[2] ^ gold[r];
            end else begin
                add_instr(r_format(FN_ADDU, 2, r, 2, 0));
                gold[2] = gold[2] + gold[r];
            end
        end
    endtask

    task automatic test_alu_ops();
        begin_program();
        add_instr(i_format(OP_ADDIU, 0, 8, 16'hFFFB));
        gold[8] = 32'hFFFFFFFB;
        add_instr(i_format(OP_LUI, 0, 9, 16'h1234));
        gold[9] = 32'h12340000;
        add_instr(i_format(OP_ORI, 9, 9, 16'h8765));
        gold[9] = gold[9] | 32'h00008765;
        add_instr(r_format(FN_ADDU, 8, 9, 10, 0));
        gold[10] = gold[8] + gold[9];
        add_instr(r_format(FN_SUBU, 9, 8, 11, 0));
        gold[11] = gold[9] - gold[8];
        add_instr(r_format(FN_AND, 10, 11, 12, 0));
        gold[12] = gold[10] & gold[11];
        add_instr(r_format(FN_OR, 10, 11, 13, 0));
        gold[13] = gold[10] | gold[11];
        add_instr(r_format(FN_XOR, 12, 13, 14, 0));
        gold[14] = gold[12] ^ gold[13];
        add_instr(r_format(FN_NOR, 14, 8, 15, 0));
        gold[15] = ~(gold[14] | gold[8]);
        add_instr(r_format(FN_SLT, 8, 9, 16, 0));
        gold[16] = {31'b0, $signed(gold[8]) < $signed(gold[9])};
        add_instr(r_format(FN_SLTU, 8, 9, 17, 0));
        gold[17] = {31'b0, gold[8] < gold[9]};
        // Both immediate compares sign-extend the immediate
        add_instr(i_format(OP_SLTI, 8, 18, 16'hFFFF));
        gold[18] = {31'b0, $signed(gold[8]) < $signed(32'hFFFFFFFF)};
        add_instr(i_format(OP_SLTIU, 9, 19, 16'hFFFF));
        gold[19] = {31'b0, gold[9] < 32'hFFFFFFFF};
        add_instr(i_format(OP_ANDI, 8, 20, 16'hF0F0));
        gold[20] = gold[8] & 32'h0000F0F0;
        add_instr(i_format(OP_XORI, 9, 21, 16'hFFFF));
        gold[21] = gold[9] ^ 32'h0000FFFF;
        add_instr(r_format(FN_SLL, 0, 9, 22, 4));
        gold[22] = {gold[9][27:0], 4'b0};
        add_instr(r_format(FN_SRL, 0, 8, 23, 8));
        gold[23] = {8'b0, gold[8][31:8]};
        add_instr(r_format(FN_SRA, 0, 8, 24, 2));
        gold[24] = {{2{gold[8][31]}}, gold[8][31:2]};
        fold_into_v0(8, 24);
        add_instr(r_format(FN_JR, 0, 0, 0, 0));
        run_program(1'b0);
        check_word("register_v0", register_v0, gold[2]);
    endtask

    task automatic test_load_store();
        begin_program();
        add_instr(i_format(OP_ADDIU, 0, 8, 16'h0040));
        add_instr(i_format(OP_LUI, 0, 9, 16'hCAFE));
        add_instr(i_format(OP_ORI, 9, 9, 16'hF00D));
        add_instr(i_format(OP_SW, 8, 9, 16'h0008));
        add_instr(i_format(OP_LW, 8, 10, 16'h0008));
        add_instr(r_format(FN_ADDU, 10, 0, 2, 0));
        add_instr(r_format(FN_JR, 0, 0, 0, 0));
        run_program(1'b0);
        check_word("register_v0", register_v0, 32'hCAFEF00D);
        check_word("write_count", 32'(mem.write_count), 32'd1);
        check_word("data_address", mem.last_write_addr, 32'h00000048);
        check_word("data_writedata", mem.last_write_data, 32'hCAFEF00D);
        check_word("ram[0x48]", mem.ram[18], 32'hCAFEF00D);
    endtask

    // Markers in v0 show which paths ran and both link values are added
    task automatic test_branches_jumps();
        begin_program();
        add_instr(i_format(OP_ADDIU, 0, 8, 16'd5));
        add_instr(i_format(OP_ADDIU, 0, 9, 16'd5));
        add_instr(i_format(OP_BEQ, 8, 9, 16'd1));
        add_instr(i_format(OP_ORI, 2, 2, 16'h0001));
        add_instr(i_format(OP_ORI, 2, 2, 16'h0002));
        add_instr(i_format(OP_BNE, 8, 9, 16'd1));
        add_instr(i_format(OP_ORI, 2, 2, 16'h0004));
        add_instr(i_format(OP_BEQ, 8, 0, 16'd1));
        add_instr(i_format(OP_ORI, 2, 2, 16'h0008));
        add_instr(i_format(OP_BNE, 8, 0, 16'd1));
        add_instr(i_format(OP_ORI, 2, 2, 16'h0010));
        add_instr(j_format(OP_J, jump_field(13)));
        add_instr(i_format(OP_ORI, 2, 2, 16'h0020));
        add_instr(j_format(OP_JAL, jump_field(15)));
        add_instr(i_format(OP_ORI, 2, 2, 16'h0040));
        add_instr(r_format(FN_ADDU, 31, 0, 16, 0));
        add_instr(i_format(OP_ORI, 2, 2, 16'h0080));
        add_instr(i_format(OP_LUI, 0, 17, reset_vector[31:16]));
        add_instr(i_format(OP_ORI, 17, 17, reset_vector[15:0] + 16'h0054));
        add_instr(r_format(FN_JALR, 17, 0, 18, 0));
        add_instr(i_format(OP_ORI, 2, 2, 16'h0100));
        add_instr(i_format(OP_ORI, 2, 2, 16'h0200));
        add_instr(r_format(FN_ADDU, 2, 16, 2, 0));
        add_instr(r_format(FN_ADDU, 2, 18, 2, 0));
        add_instr(r_format(FN_JR, 0, 0, 0, 0));
        gold[2] = 32'h0000028E + (reset_vector + 32'd56) + (reset_vector + 32'd80);
        run_program(1'b0);
        check_word("register_v0", register_v0, gold[2]);
    endtask

    task automatic test_hi_lo();
        logic [31:0]     a;
        logic [31:0]     b;
        int              sa;
        int              sb;
        longint          ps;
        longint unsigned pu;
        a  = 32'h9ABCDEF0;
        b  = 32'h12345678;
        sa = a;
        sb = b;
        ps = longint'(sa) * longint'(sb);
        pu = longint'({32'b0, a}) * longint'({32'b0, b});
        begin_program();
        add_instr(i_format(OP_LUI, 0, 8, a[31:16]));
        add_instr(i_format(OP_ORI, 8, 8, a[15:0]));
        add_instr(i_format(OP_LUI, 0, 9, b[31:16]));
        add_instr(i_format(OP_ORI, 9, 9, b[15:0]));
        add_instr(r_format(FN_MULT, 8, 9, 0, 0));
        add_instr(r_format(FN_MFHI, 0, 0, 10, 0));
        add_instr(r_format(FN_MFLO, 0, 0, 11, 0));
        add_instr(r_format(FN_MULTU, 8, 9, 0, 0));
        add_instr(r_format(FN_MFHI, 0, 0, 12, 0));
        add_instr(r_format(FN_MFLO, 0, 0, 13, 0));
        add_instr(r_format(FN_DIV, 8, 9, 0, 0));
        add_instr(r_format(FN_MFHI, 0, 0, 14, 0));
        add_instr(r_format(FN_MFLO, 0, 0, 15, 0));
        add_instr(r_format(FN_DIVU, 8, 9, 0, 0));
        add_instr(r_format(FN_MFHI, 0, 0, 16, 0));
        add_instr(r_format(FN_MFLO, 0, 0, 17, 0));
        // Divide by zero must keep the divu results
        add_instr(r_format(FN_DIV, 8, 0, 0, 0));
        add_instr(r_format(FN_MFHI, 0, 0, 18, 0));
        add_instr(r_format(FN_MFLO, 0, 0, 19, 0));
        gold[10] = ps[63:32];
        gold[11] = ps[31:0];
        gold[12] = pu[63:32];
        gold[13] = pu[31:0];
        gold[14] = sa % sb;
        gold[15] = sa / sb;
        gold[16] = a % b;
        gold[17] = a / b;
        gold[18] = gold[16];
        gold[19] = gold[17];
        fold_into_v0(10, 19);
        add_instr(r_format(FN_JR, 0, 0, 0, 0));
        run_program(1'b0);
        check_word("register_v0", register_v0, gold[2]);
    endtask

    // Stores 4, 3, 2, 1 from address 0x100 on and sums them into v0
    task automatic load_store_loop();
        begin_program();
        add_instr(i_format(OP_ADDIU, 0, 8, 16'd4));
        add_instr(i_format(OP_ADDIU, 0, 9, 16'h0100));
        add_instr(i_format(OP_SW, 9, 8, 16'h0000));
        add_instr(r_format(FN_ADDU, 2, 8, 2, 0));
        add_instr(i_format(OP_ADDIU, 9, 9, 16'd4));
        add_instr(i_format(OP_ADDIU, 8, 8, 16'hFFFF));
        add_instr(i_format(OP_BNE, 8, 0, 16'hFFFB));
        add_instr(r_format(FN_JR, 0, 0, 0, 0));
    endtask

    task automatic test_halt_and_stall();
        logic [31:0] v0_ref;
        logic [31:0] ram_ref [4];
        int          writes;
        load_store_loop();
        run_program(1'b0);
        check_word("instr_address", instr_address, 32'h0);
        check_word("register_v0", register_v0, 32'd10);
        for (int i = 0; i < 4; i++) begin
            check_word($sformatf("ram[%0d]", 64 + i), mem.ram[64 + i], 32'(4 - i));
            ram_ref[i] = mem.ram[64 + i];
        end
        v0_ref = register_v0;
        writes = mem.write_count;
        // Nothing may move once halted
        repeat (20) @(negedge clk);
        check_bit("active", active, 1'b0);
        check_word("instr_address", instr_address, 32'h0);
        check_word("register_v0", register_v0, v0_ref);
        check_word("write_count", 32'(mem.write_count), 32'(writes));
        load_store_loop();
        run_program(1'b1);
        check_word("instr_address", instr_address, 32'h0);
        check_word("register_v0", register_v0, v0_ref);
        for (int i = 0; i < 4; i++) begin
            check_word($sformatf("ram[%0d]", 64 + i), mem.ram[64 + i], ram_ref[i]);
        end
    endtask

    initial begin
        #(CLK_PERIOD * CYCLES_PER_TEST * TEST_COUNT);
        report_failure("Timeout: the CPU did not halt within the cycle budget of the tests");
    end

    initial begin
        seed       = 32'ha071faef;
        clk        = 1'b0;
        arst_n     = 1'b0;
        clk_enable = 1'b0;
        prog_len   = 0;
        test_alu_ops();
        test_load_store();
        test_branches_jumps();
        test_hi_lo();
        test_halt_and_stall();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: testbench/mips_tb_memory.sv
`timescale 1ns/1ps

module mips_tb_memory (
    input  logic        clk,
    input  logic        clk_enable,
    input  logic [31:0] instr_address,
    output logic [31:0] instr_readdata,
    input  logic [31:0] data_address,
    input  logic        data_write,
    input  logic        data_read,
    input  logic [31:0] data_writedata,
    output logic [31:0] data_readdata
);
    import mips_pkg::*;

    localparam int MEM_WORDS = 256;

    logic [31:0] rom [MEM_WORDS];
    logic [31:0] ram [MEM_WORDS];
    logic [31:0] rom_offset;

    // Write observer, cleared by the testbench between programs
    int          write_count = 0;
    logic [31:0] last_write_addr;
    logic [31:0] last_write_data;

    // ROM starts at the reset vector, anything outside reads as a nop
    assign rom_offset     = instr_address - reset_vector;
    assign instr_readdata = (rom_offset < MEM_WORDS * 4) ? rom[rom_offset[9:2]] : 32'b0;

    assign data_readdata = data_read ? ram[data_address[9:2]] : 32'b0;

    always @(posedge clk) begin
        if (data_write && clk_enable) begin
            ram[data_address[9:2]] <= data_writedata;
            write_count            <= write_count + 1;
            last_write_addr        <= data_address;
            last_write_data        <= data_writedata;
        end
    end

endmodule

// File: hdl/mips_cpu_harvard.sv
`timescale 1ns/1ps

module mips_cpu_harvard #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        clk_enable,
    output logic        active,
    output logic [31:0] register_v0,
    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,
    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata
);
    import mips_pkg::*;

    mips_instr_t instr;

    logic       reg_dst;
    logic       alu_src;
    logic       sign_ext;
    logic       branch_eq;
    logic       branch_ne;
    logic       jump;
    logic       jump_reg;
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    logic       link_ra;
    alu_class_e alu_class;
    muldiv_op_e muldiv_op;
    wb_sel_e    wb_sel;

    alu_op_e     alu_op;
    logic        shift_var;
    logic [4:0]  shift_amount;
    logic [31:0] imm_ext;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        alu_zero;
    logic        branch_taken;

    logic [31:0]           rs_data;
    logic [31:0]           rt_data;
    logic [4:0]            write_index;
    logic [31:0]           write_data;
    logic [31:0]           hi;
    logic [31:0]           lo;
    logic [ADDR_WIDTH-1:0] pc;
    logic [31:0]           link_addr;

    assign instr         = instr_readdata;
    assign instr_address = 32'(pc);

    mips_control u_control (
        .instr     (instr),
        .reg_dst   (reg_dst),
        .alu_src   (alu_src),
        .sign_ext  (sign_ext),
        .branch_eq (branch_eq),
        .branch_ne (branch_ne),
        .jump      (jump),
        .jump_reg  (jump_reg),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .reg_write (reg_write),
        .link_ra   (link_ra),
        .alu_class (alu_class),
        .muldiv_op (muldiv_op),
        .wb_sel    (wb_sel)
    );

    mips_alu_control u_alu_control (
        .alu_class (alu_class),
        .instr     (instr),
        .alu_op    (alu_op),
        .shift_var (shift_var)
    );

    // Operand B and shift amount
    assign imm_ext      = sign_ext ? {{16{instr.i.imm[15]}}, instr.i.imm}
                                   : {16'b0, instr.i.imm};
    assign alu_b        = alu_src ? imm_ext : rt_data;
    assign shift_amount = shift_var ? rs_data[4:0] : instr.r.shamt;

    mips_alu u_alu (
        .alu_op (alu_op),
        .a      (rs_data),
        .b      (alu_b),
        .shamt  (shift_amount),
        .result (alu_result),
        .zero   (alu_zero)
    );

    assign branch_taken = (branch_eq && alu_zero) || (branch_ne && !alu_zero);

    // jal links to r31, jalr and R-type write rd
    assign write_index = link_ra ? 5'd31 : (reg_dst ? instr.r.rd : instr.r.rt);

    always_comb begin
        case (wb_sel)
            WB_MEM:  write_data = data_readdata;
            WB_LINK: write_data = link_addr;
            WB_HI:   write_data = hi;
            WB_LO:   write_data = lo;
            default: write_data = alu_result;
        endcase
    end

    mips_regfile u_regfile (
        .clk          (clk),
        .arst_n       (arst_n),
        .clk_enable   (clk_enable),
        .write_enable (reg_write && active),
        .rs_index     (instr.r.rs),
        .rt_index     (instr.r.rt),
        .rd_index     (write_index),
        .write_data   (write_data),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .register_v0  (register_v0)
    );

    mips_muldiv u_muldiv (
        .clk        (clk),
        .arst_n     (arst_n),
        .clk_enable (clk_enable),
        .muldiv_op  (active ? muldiv_op : MD_NONE),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .hi         (hi),
        .lo         (lo)
    );

    mips_pc #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_pc (
        .clk          (clk),
        .arst_n       (arst_n),
        .clk_enable   (clk_enable),
        .instr        (instr),
        .branch_taken (branch_taken),
        .jump         (jump),
        .jump_reg     (jump_reg),
        .rs_data      (rs_data),
        .pc           (pc),
        .link_addr    (link_addr),
        .active       (active)
    );

    // Data port, address straight from the ALU
    assign data_address   = alu_result;
    assign data_read      = mem_read;
    assign data_write     = mem_write && active;
    assign data_writedata = rt_data;

endmodule

// File: hdl/mips_pc.sv
`timescale 1ns/1ps

module mips_pc #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  clk_enable,
    input  mips_pkg::mips_instr_t instr,
    input  logic                  branch_taken,
    input  logic                  jump,
    input  logic                  jump_reg,
    input  logic [31:0]           rs_data,
    output logic [ADDR_WIDTH-1:0] pc,
    output logic [31:0]           link_addr,
    output logic                  active
);
    import mips_pkg::*;

    localparam logic [ADDR_WIDTH-1:0] reset_pc = reset_vector[ADDR_WIDTH-1:0];

    logic [31:0]           branch_target;
    logic [31:0]           jump_target;
    logic [ADDR_WIDTH-1:0] next_pc;

    // Targets are formed at full width, then cut to the PC width
    assign link_addr     = 32'(pc) + 32'd4;
    assign branch_target = link_addr + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
    assign jump_target   = {link_addr[31:28], instr.j.target, 2'b00};

    always_comb begin
        if (branch_taken) begin
            next_pc = branch_target[ADDR_WIDTH-1:0];
        end else if (jump) begin
            next_pc = jump_target[ADDR_WIDTH-1:0];
        end else if (jump_reg) begin
            next_pc = rs_data[ADDR_WIDTH-1:0];
        end else begin
            next_pc = link_addr[ADDR_WIDTH-1:0];
        end
    end

    // Halted at address 0, PC stays put
    assign active = (pc != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
        end else if (clk_enable && active) begin
            pc <= next_pc;
        end
    end

endmodule

// File: hdl/mips_muldiv.sv
`timescale 1ns/1ps

module mips_muldiv (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 clk_enable,
    input  mips_pkg::muldiv_op_e muldiv_op,
    input  logic [31:0]          rs_data,
    input  logic [31:0]          rt_data,
    output logic [31:0]          hi,
    output logic [31:0]          lo
);
    import mips_pkg::*;

    logic [63:0] product_s;
    logic [63:0] product_u;
    logic [31:0] quot_s;
    logic [31:0] rem_s;
    logic [31:0] quot_u;
    logic [31:0] rem_u;
    logic        div_by_zero;

    // Operands widened to 64 bits before the multiply
    assign product_s = $signed({{32{rs_data[31]}}, rs_data})
                     * $signed({{32{rt_data[31]}}, rt_data});
    assign product_u = {32'b0, rs_data} * {32'b0, rt_data};

    assign quot_s = $signed(rs_data) / $signed(rt_data);
    assign rem_s  = $signed(rs_data) % $signed(rt_data);
    assign quot_u = rs_data / rt_data;
    assign rem_u  = rs_data % rt_data;

    assign div_by_zero = (rt_data == 32'b0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi <= 32'b0;
            lo <= 32'b0;
        end else if (clk_enable) begin
            case (muldiv_op)
                MD_MULT:  {hi, lo} <= product_s;
                MD_MULTU: {hi, lo} <= product_u;
                MD_DIV: begin
                    if (!div_by_zero) begin
                        hi <= rem_s;
                        lo <= quot_s;
                    end
                end
                MD_DIVU: begin
                    if (!div_by_zero) begin
                        hi <= rem_u;
                        lo <= quot_u;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// File: hdl/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        clk_enable,
    input  logic        write_enable,
    input  logic [4:0]  rs_index,
    input  logic [4:0]  rt_index,
    input  logic [4:0]  rd_index,
    input  logic [31:0] write_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    output logic [31:0] register_v0
);

    logic [31:0] regs [32];

    // Register 0 is cleared on reset and never written, so it reads 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (clk_enable && write_enable && (rd_index != 5'd0)) begin
            regs[rd_index] <= write_data;
        end
    end

    assign rs_data     = regs[rs_index];
    assign rt_data     = regs[rt_index];
    assign register_v0 = regs[2];

endmodule

// File: hdl/mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::alu_op_e alu_op,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    input  logic [4:0]        shamt,
    output logic [31:0]       result,
    output logic              zero
);
    import mips_pkg::*;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            // Shifts take their operand from b, as rt does in MIPS
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_SRA:  result = $signed(b) >>> shamt;
            ALU_LUI:  result = {b[15:0], 16'b0};
            default:  result = 32'b0;
        endcase
    end

    // Equality test for beq and bne after a SUB
    assign zero = (result == 32'b0);

endmodule

// File: hdl/mips_alu_control.sv
`timescale 1ns/1ps

module mips_alu_control (
    input  mips_pkg::alu_class_e  alu_class,
    input  mips_pkg::mips_instr_t instr,
    output mips_pkg::alu_op_e     alu_op,
    output logic                  shift_var
);
    import mips_pkg::*;

    // Variable shifts (sllv, srlv, srav) sit in funct 04..07
    assign shift_var = (alu_class == CLS_FUNCT) && (instr.r.funct[5:2] == 4'b0001);

    always_comb begin
        alu_op = ALU_ADD;
        case (alu_class)
            CLS_ADD: alu_op = ALU_ADD;
            CLS_SUB: alu_op = ALU_SUB;
            CLS_FUNCT: begin
                case (instr.r.funct)
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    default: alu_op = ALU_ADD;
                endcase
            end
            CLS_IMM: begin
                case (instr.i.opcode)
                    OP_ANDI:  alu_op = ALU_AND;
                    OP_ORI:   alu_op = ALU_OR;
                    OP_XORI:  alu_op = ALU_XOR;
                    OP_SLTI:  alu_op = ALU_SLT;
                    OP_SLTIU: alu_op = ALU_SLTU;
                    OP_LUI:   alu_op = ALU_LUI;
                    default:  alu_op = ALU_ADD;
                endcase
            end
            default: alu_op = ALU_ADD;
        endcase
    end

endmodule

// File: hdl/mips_control.sv
`timescale 1ns/1ps

module mips_control (
    input  mips_pkg::mips_instr_t instr,
    output logic                  reg_dst,
    output logic                  alu_src,
    output logic                  sign_ext,
    output logic                  branch_eq,
    output logic                  branch_ne,
    output logic                  jump,
    output logic                  jump_reg,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  reg_write,
    output logic                  link_ra,
    output mips_pkg::alu_class_e  alu_class,
    output mips_pkg::muldiv_op_e  muldiv_op,
    output mips_pkg::wb_sel_e     wb_sel
);
    import mips_pkg::*;

    always_comb begin
        // Defaults give a no-op for anything not decoded below
        reg_dst   = 1'b0;
        alu_src   = 1'b0;
        sign_ext  = 1'b0;
        branch_eq = 1'b0;
        branch_ne = 1'b0;
        jump      = 1'b0;
        jump_reg  = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        link_ra   = 1'b0;
        alu_class = CLS_ADD;
        muldiv_op = MD_NONE;
        wb_sel    = WB_ALU;

        case (instr.r.opcode)
            OP_SPECIAL: begin
                reg_dst   = 1'b1;
                alu_class = CLS_FUNCT;
                case (instr.r.funct)
                    FN_SLL, FN_SRL, FN_SRA, FN_ADDU, FN_SUBU, FN_AND,
                    FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU: reg_write = 1'b1;
                    FN_JR:    jump_reg = 1'b1;
                    FN_JALR: begin
                        jump_reg  = 1'b1;
                        reg_write = 1'b1;
                        wb_sel    = WB_LINK;
                    end
                    FN_MFHI: begin
                        reg_write = 1'b1;
                        wb_sel    = WB_HI;
                    end
                    FN_MFLO: begin
                        reg_write = 1'b1;
                        wb_sel    = WB_LO;
                    end
                    FN_MULT:  muldiv_op = MD_MULT;
                    FN_MULTU: muldiv_op = MD_MULTU;
                    FN_DIV:   muldiv_op = MD_DIV;
                    FN_DIVU:  muldiv_op = MD_DIVU;
                    default: ;
                endcase
            end
            OP_J:   jump = 1'b1;
            OP_JAL: begin
                jump      = 1'b1;
                reg_write = 1'b1;
                link_ra   = 1'b1;
                wb_sel    = WB_LINK;
            end
            OP_BEQ: begin
                branch_eq = 1'b1;
                alu_class = CLS_SUB;
            end
            OP_BNE: begin
                branch_ne = 1'b1;
                alu_class = CLS_SUB;
            end
            OP_ADDIU: begin
                alu_src   = 1'b1;
                sign_ext  = 1'b1;
                reg_write = 1'b1;
            end
            // sltiu still sign-extends, only the compare is unsigned
            OP_SLTI, OP_SLTIU: begin
                alu_src   = 1'b1;
                sign_ext  = 1'b1;
                reg_write = 1'b1;
                alu_class = CLS_IMM;
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
                alu_class = CLS_IMM;
            end
            OP_LW: begin
                alu_src   = 1'b1;
                sign_ext  = 1'b1;
                mem_read  = 1'b1;
                reg_write = 1'b1;
                wb_sel    = WB_MEM;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                sign_ext  = 1'b1;
                mem_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/mips_pkg.sv
package mips_pkg;

    // Reset vector for the instruction fetch, in the boot ROM segment
    localparam logic [31:0] reset_vector = 32'hBFC00000;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // Function field of SPECIAL instructions
    typedef enum logic [5:0] {
        FN_SLL   = 6'h00,
        FN_SRL   = 6'h02,
        FN_SRA   = 6'h03,
        FN_JR    = 6'h08,
        FN_JALR  = 6'h09,
        FN_MFHI  = 6'h10,
        FN_MFLO  = 6'h12,
        FN_MULT  = 6'h18,
        FN_MULTU = 6'h19,
        FN_DIV   = 6'h1a,
        FN_DIVU  = 6'h1b,
        FN_ADDU  = 6'h21,
        FN_SUBU  = 6'h23,
        FN_AND   = 6'h24,
        FN_OR    = 6'h25,
        FN_XOR   = 6'h26,
        FN_NOR   = 6'h27,
        FN_SLT   = 6'h2a,
        FN_SLTU  = 6'h2b
    } funct_e;

    typedef enum logic [1:0] {CLS_ADD, CLS_SUB, CLS_FUNCT, CLS_IMM} alu_class_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {MD_NONE, MD_MULT, MD_MULTU, MD_DIV, MD_DIVU} muldiv_op_e;

    typedef enum logic [2:0] {WB_ALU, WB_MEM, WB_LINK, WB_HI, WB_LO} wb_sel_e;

    // One instruction word, seen as R, I or J format
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } j;
    } mips_instr_t;

endpackage
